// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  // Datapath and instruction width
  localparam int dataW = 32;
  // Sixteen architectural registers
  localparam int regAddrW = 4;
  // Word address into either memory
  localparam int addrW = 16;

  // Instruction word fields
  localparam int opcodeMsb = 31;
  localparam int opcodeLsb = 28;
  localparam int rdMsb = 27;
  localparam int rdLsb = 24;
  localparam int rnMsb = 23;
  localparam int rnLsb = 20;
  localparam int rmMsb = 19;
  localparam int rmLsb = 16;
  localparam int immMsb = 15;
  localparam int immLsb = 0;

  // All-zero word decodes as a nop with no destination
  localparam logic [dataW-1:0] nopInstr = '0;

  typedef enum logic [3:0] {
    opNop  = 4'h0,
    opAdd  = 4'h1,
    opSub  = 4'h2,
    opAnd  = 4'h3,
    opOr   = 4'h4,
    opAddi = 4'h5,
    opLdr  = 4'h6,
    opStr  = 4'h7,
    opBeq  = 4'h8
  } opcodeE;

  // Operand source into execute
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } forwardE;

endpackage

`default_nettype wire

// ==== source/hazardIf.sv ====
`default_nettype none

interface hazardIf;

  // Register numbers seen by the hazard unit, per stage
  logic [cpuPkg::regAddrW-1:0] srcAD, srcBD;
  logic [cpuPkg::regAddrW-1:0] srcAE, srcBE, destE;
  logic [cpuPkg::regAddrW-1:0] destM, destW;
  logic                        memToRegE, branchTakenE;
  logic                        regWriteM, regWriteW;
  // Memory wait indications
  logic                        iStall, dStall;
  // Pipeline control back to the stages
  cpuPkg::forwardE             forwardAE, forwardBE;
  logic                        stallF, stallD, stallE, stallM;
  logic                        flushD, flushE, flushW;

  modport hazard (
    input  srcAD, srcBD, srcAE, srcBE, destE, memToRegE, branchTakenE,
    input  destM, regWriteM, destW, regWriteW, iStall, dStall,
    output forwardAE, forwardBE, stallF, stallD, stallE, stallM,
    output flushD, flushE, flushW
  );
  modport fetch (output iStall, input stallF, flushD);
  modport decode (output srcAD, srcBD, input destW, regWriteW, stallD, flushE);
  modport execute (
    output srcAE, srcBE, destE, memToRegE, branchTakenE,
    input  forwardAE, forwardBE, stallE, flushE
  );
  modport memory (output destM, regWriteM, destW, regWriteW, dStall, input stallM, flushW);

endinterface

`default_nettype wire

// ==== source/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
  hazardIf.hazard haz
);

  logic ldrStallD;
  logic frontStall;

  // Newest producer wins, register 0 never carries a write
  function automatic cpuPkg::forwardE pickForward(
    input logic [cpuPkg::regAddrW-1:0] src,
    input logic [cpuPkg::regAddrW-1:0] destM,
    input logic                        writeM,
    input logic [cpuPkg::regAddrW-1:0] destW,
    input logic                        writeW
  );
    if (writeM && (src == destM))
      return cpuPkg::fwdMem;
    else if (writeW && (src == destW))
      return cpuPkg::fwdWb;
    else
      return cpuPkg::fwdNone;
  endfunction

  assign haz.forwardAE = pickForward(haz.srcAE, haz.destM, haz.regWriteM,
                                     haz.destW, haz.regWriteW);
  assign haz.forwardBE = pickForward(haz.srcBE, haz.destM, haz.regWriteM,
                                     haz.destW, haz.regWriteW);

  // Load in execute feeding the instruction in decode
  assign ldrStallD = haz.memToRegE &&
                     ((haz.srcAD == haz.destE) || (haz.srcBD == haz.destE));

  // Fetch and decode hold for a load-use or a data memory wait
  assign frontStall = ldrStallD | haz.dStall;

  assign haz.stallF = frontStall;
  assign haz.stallD = frontStall;
  // Data memory wait freezes everything up to memory
  assign haz.stallE = haz.dStall;
  assign haz.stallM = haz.dStall;

  // A held decode slot is never overwritten by a bubble
  assign haz.flushD = (haz.branchTakenE | haz.iStall) & ~frontStall;
  // Bubble into execute, unless execute itself is frozen
  assign haz.flushE = (ldrStallD | haz.branchTakenE) & ~haz.dStall;
  // Memory stage still busy, so nothing retires
  assign haz.flushW = haz.dStall;

endmodule

`default_nettype wire

// ==== source/fetchStage.sv ====
`default_nettype none

module fetchStage (
  input  logic                     clk,
  input  logic                     rstN,
  hazardIf.fetch                   haz,
  output logic [cpuPkg::addrW-1:0] imemAddr,
  input  logic [cpuPkg::dataW-1:0] imemData,
  input  logic                     imemReady,
  input  logic                     branchTakenE,
  input  logic [cpuPkg::addrW-1:0] branchTargetE,
  output logic [cpuPkg::dataW-1:0] instrD,
  output logic [cpuPkg::addrW-1:0] pcD
);

  logic [cpuPkg::addrW-1:0] pcF;
  logic [cpuPkg::addrW-1:0] pcNextF;

  // Instruction memory always looks at the current PC
  assign imemAddr = pcF;
  assign haz.iStall = ~imemReady;

  // A branch seen during a freeze is taken again once the freeze ends
  always_comb
  begin
    if (haz.stallF)
      pcNextF = pcF;
    else if (branchTakenE)
      pcNextF = branchTargetE;
    else if (imemReady)
      pcNextF = pcF + cpuPkg::addrW'(1);
    else
      pcNextF = pcF;
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      pcF <= '0;
    else
      pcF <= pcNextF;
  end

  // Fetch/decode register, nop on branch or missing instruction
  always_ff @(posedge clk)
  begin
    if (!rstN)
      instrD <= cpuPkg::nopInstr;
    else if (haz.flushD)
      instrD <= cpuPkg::nopInstr;
    else if (!haz.stallF)
      instrD <= imemData;
  end

  always_ff @(posedge clk)
  begin
    if (!haz.stallF)
      pcD <= pcF;
  end

endmodule

`default_nettype wire

// ==== source/decodeStage.sv ====
`default_nettype none

module decodeStage (
  input  logic                        clk,
  input  logic                        rstN,
  hazardIf.decode                     haz,
  input  logic [cpuPkg::dataW-1:0]    instrD,
  input  logic [cpuPkg::addrW-1:0]    pcD,
  input  logic [cpuPkg::dataW-1:0]    resultW,
  output cpuPkg::opcodeE              opE,
  output logic [cpuPkg::dataW-1:0]    operandAE,
  output logic [cpuPkg::dataW-1:0]    operandBE,
  output logic [cpuPkg::dataW-1:0]    immE,
  output logic [cpuPkg::addrW-1:0]    pcE,
  output logic [cpuPkg::regAddrW-1:0] srcRegAE,
  output logic [cpuPkg::regAddrW-1:0] srcRegBE,
  output logic [cpuPkg::regAddrW-1:0] destRegE
);

  cpuPkg::opcodeE              opD;
  logic [cpuPkg::regAddrW-1:0] rnD;
  logic [cpuPkg::regAddrW-1:0] rmD;
  logic [cpuPkg::regAddrW-1:0] destD;
  logic [cpuPkg::dataW-1:0]    immD;
  logic [cpuPkg::dataW-1:0]    readAD;
  logic [cpuPkg::dataW-1:0]    readBD;
  logic [cpuPkg::dataW-1:0]    regFile [0:(1 << cpuPkg::regAddrW)-1];

  assign opD = cpuPkg::opcodeE'(instrD[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb]);
  assign rnD = instrD[cpuPkg::rnMsb:cpuPkg::rnLsb];
  // Sign-extended 16-bit immediate
  assign immD = {{(cpuPkg::dataW - cpuPkg::immMsb - 1){instrD[cpuPkg::immMsb]}},
                 instrD[cpuPkg::immMsb:cpuPkg::immLsb]};

  // Only register-register, store and branch read rm
  // Destination 0 stands for no write at all
  always_comb
  begin
    rmD = '0;
    destD = '0;
    case (opD)
      cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr:
      begin
        rmD = instrD[cpuPkg::rmMsb:cpuPkg::rmLsb];
        destD = instrD[cpuPkg::rdMsb:cpuPkg::rdLsb];
      end
      cpuPkg::opAddi, cpuPkg::opLdr:
        destD = instrD[cpuPkg::rdMsb:cpuPkg::rdLsb];
      cpuPkg::opStr, cpuPkg::opBeq:
        rmD = instrD[cpuPkg::rmMsb:cpuPkg::rmLsb];
      default:
        destD = '0;
    endcase
  end

  assign haz.srcAD = rnD;
  assign haz.srcBD = rmD;

  // Read ports, r0 is zero and a writeback in this cycle passes through
  always_comb
  begin
    if (rnD == '0)
      readAD = '0;
    else if (haz.regWriteW && (haz.destW == rnD))
      readAD = resultW;
    else
      readAD = regFile[rnD];
    if (rmD == '0)
      readBD = '0;
    else if (haz.regWriteW && (haz.destW == rmD))
      readBD = resultW;
    else
      readBD = regFile[rmD];
  end

  // Writeback port
  always_ff @(posedge clk)
  begin
    if (haz.regWriteW)
      regFile[haz.destW] <= resultW;
  end

  // Decode/execute control, flush has the last word
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      opE <= cpuPkg::opNop;
      destRegE <= '0;
    end
    else if (haz.flushE)
    begin
      opE <= cpuPkg::opNop;
      destRegE <= '0;
    end
    else if (!haz.stallD)
    begin
      opE <= opD;
      destRegE <= destD;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!haz.stallD)
    begin
      operandAE <= readAD;
      operandBE <= readBD;
      immE <= immD;
      pcE <= pcD;
      srcRegAE <= rnD;
      srcRegBE <= rmD;
    end
  end

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`default_nettype none

module executeStage (
  input  logic                        clk,
  input  logic                        rstN,
  hazardIf.execute                    haz,
  input  cpuPkg::opcodeE              opE,
  input  logic [cpuPkg::dataW-1:0]    operandAE,
  input  logic [cpuPkg::dataW-1:0]    operandBE,
  input  logic [cpuPkg::dataW-1:0]    immE,
  input  logic [cpuPkg::addrW-1:0]    pcE,
  input  logic [cpuPkg::regAddrW-1:0] srcRegAE,
  input  logic [cpuPkg::regAddrW-1:0] srcRegBE,
  input  logic [cpuPkg::regAddrW-1:0] destRegE,
  input  logic [cpuPkg::dataW-1:0]    aluResultM,
  input  logic [cpuPkg::dataW-1:0]    resultW,
  output logic                        branchTakenE,
  output logic [cpuPkg::addrW-1:0]    branchTargetE,
  output cpuPkg::opcodeE              opM,
  output logic [cpuPkg::dataW-1:0]    aluOutM,
  output logic [cpuPkg::dataW-1:0]    storeDataM,
  output logic [cpuPkg::regAddrW-1:0] destRegM
);

  logic [cpuPkg::dataW-1:0] srcA;
  logic [cpuPkg::dataW-1:0] srcB;
  logic [cpuPkg::dataW-1:0] aluOutE;

  assign haz.srcAE = srcRegAE;
  assign haz.srcBE = srcRegBE;
  assign haz.destE = destRegE;
  assign haz.memToRegE = (opE == cpuPkg::opLdr) && (destRegE != '0);

  // Forwarding muxes
  always_comb
  begin
    case (haz.forwardAE)
      cpuPkg::fwdMem: srcA = aluResultM;
      cpuPkg::fwdWb:  srcA = resultW;
      default:        srcA = operandAE;
    endcase
    case (haz.forwardBE)
      cpuPkg::fwdMem: srcB = aluResultM;
      cpuPkg::fwdWb:  srcB = resultW;
      default:        srcB = operandBE;
    endcase
  end

  // ALU, loads and stores use it for rn plus imm
  always_comb
  begin
    case (opE)
      cpuPkg::opAdd:  aluOutE = srcA + srcB;
      cpuPkg::opSub:  aluOutE = srcA - srcB;
      cpuPkg::opAnd:  aluOutE = srcA & srcB;
      cpuPkg::opOr:   aluOutE = srcA | srcB;
      cpuPkg::opAddi, cpuPkg::opLdr, cpuPkg::opStr:
        aluOutE = srcA + immE;
      default:        aluOutE = '0;
    endcase
  end

  // Branch resolves here, target relative to its own PC
  assign branchTakenE = (opE == cpuPkg::opBeq) && (srcA == srcB);
  assign branchTargetE = pcE + immE[cpuPkg::addrW-1:0];
  assign haz.branchTakenE = branchTakenE;

  // Execute/memory register
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      opM <= cpuPkg::opNop;
      destRegM <= '0;
    end
    else if (!haz.stallE)
    begin
      opM <= opE;
      destRegM <= destRegE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!haz.stallE)
    begin
      aluOutM <= aluOutE;
      storeDataM <= srcB;
    end
  end

endmodule

`default_nettype wire

// ==== source/memoryStage.sv ====
`default_nettype none

module memoryStage (
  input  logic                        clk,
  input  logic                        rstN,
  hazardIf.memory                     haz,
  input  cpuPkg::opcodeE              opM,
  input  logic [cpuPkg::dataW-1:0]    aluOutM,
  input  logic [cpuPkg::dataW-1:0]    storeDataM,
  input  logic [cpuPkg::regAddrW-1:0] destRegM,
  output logic                        dmemReq,
  output logic                        dmemWe,
  output logic [cpuPkg::addrW-1:0]    dmemAddr,
  output logic [cpuPkg::dataW-1:0]    dmemWdata,
  input  logic [cpuPkg::dataW-1:0]    dmemRdata,
  input  logic                        dmemReady,
  output logic [cpuPkg::dataW-1:0]    resultW,
  output logic                        retireValid,
  output logic [cpuPkg::regAddrW-1:0] retireReg,
  output logic [cpuPkg::dataW-1:0]    retireData
);

  logic                        writeW;
  logic [cpuPkg::regAddrW-1:0] destRegW;
  logic [cpuPkg::dataW-1:0]    resultM;

  // Request fields come straight from the frozen execute/memory register
  assign dmemReq = (opM == cpuPkg::opLdr) || (opM == cpuPkg::opStr);
  assign dmemWe = (opM == cpuPkg::opStr);
  assign dmemAddr = aluOutM[cpuPkg::addrW-1:0];
  assign dmemWdata = storeDataM;
  assign haz.dStall = dmemReq & ~dmemReady;

  assign haz.destM = destRegM;
  assign haz.regWriteM = (destRegM != '0);

  // Load data is only sampled in the cycle it is ready
  assign resultM = (opM == cpuPkg::opLdr) ? dmemRdata : aluOutM;

  // Memory/writeback register, bubble while the access waits
  always_ff @(posedge clk)
  begin
    if (!rstN)
      writeW <= 1'b0;
    else if (haz.flushW)
      writeW <= 1'b0;
    else if (!haz.stallM)
      writeW <= (destRegM != '0);
  end

  always_ff @(posedge clk)
  begin
    if (!haz.stallM)
    begin
      destRegW <= destRegM;
      resultW <= resultM;
    end
  end

  assign haz.destW = destRegW;
  assign haz.regWriteW = writeW;

  // Every writeback write is also a retire event
  assign retireValid = writeW;
  assign retireReg = destRegW;
  assign retireData = resultW;

endmodule

`default_nettype wire

// ==== source/pipeCore.sv ====
`default_nettype none

module pipeCore (
  input  logic                        clk,
  input  logic                        rstN,
  output logic [cpuPkg::addrW-1:0]    imemAddr,
  input  logic [cpuPkg::dataW-1:0]    imemData,
  input  logic                        imemReady,
  output logic                        dmemReq,
  output logic                        dmemWe,
  output logic [cpuPkg::addrW-1:0]    dmemAddr,
  output logic [cpuPkg::dataW-1:0]    dmemWdata,
  input  logic [cpuPkg::dataW-1:0]    dmemRdata,
  input  logic                        dmemReady,
  output logic                        retireValid,
  output logic [cpuPkg::regAddrW-1:0] retireReg,
  output logic [cpuPkg::dataW-1:0]    retireData
);

  // Fetch to decode
  logic [cpuPkg::dataW-1:0]    instrD;
  logic [cpuPkg::addrW-1:0]    pcD;
  // Decode to execute
  cpuPkg::opcodeE              opE;
  logic [cpuPkg::dataW-1:0]    operandAE;
  logic [cpuPkg::dataW-1:0]    operandBE;
  logic [cpuPkg::dataW-1:0]    immE;
  logic [cpuPkg::addrW-1:0]    pcE;
  logic [cpuPkg::regAddrW-1:0] srcRegAE;
  logic [cpuPkg::regAddrW-1:0] srcRegBE;
  logic [cpuPkg::regAddrW-1:0] destRegE;
  // Branch redirect
  logic                        branchTakenE;
  logic [cpuPkg::addrW-1:0]    branchTargetE;
  // Execute to memory, ALU result also forwarded back
  cpuPkg::opcodeE              opM;
  logic [cpuPkg::dataW-1:0]    aluResultM;
  logic [cpuPkg::dataW-1:0]    storeDataM;
  logic [cpuPkg::regAddrW-1:0] destRegM;
  // Writeback result to decode and execute
  logic [cpuPkg::dataW-1:0]    resultW;

  hazardIf haz ();

  hazardUnit uHazard (
    .haz (haz.hazard)
  );

  fetchStage uFetch (
    .clk           (clk),
    .rstN          (rstN),
    .haz           (haz.fetch),
    .imemAddr      (imemAddr),
    .imemData      (imemData),
    .imemReady     (imemReady),
    .branchTakenE  (branchTakenE),
    .branchTargetE (branchTargetE),
    .instrD        (instrD),
    .pcD           (pcD)
  );

  decodeStage uDecode (
    .clk       (clk),
    .rstN      (rstN),
    .haz       (haz.decode),
    .instrD    (instrD),
    .pcD       (pcD),
    .resultW   (resultW),
    .opE       (opE),
    .operandAE (operandAE),
    .operandBE (operandBE),
    .immE      (immE),
    .pcE       (pcE),
    .srcRegAE  (srcRegAE),
    .srcRegBE  (srcRegBE),
    .destRegE  (destRegE)
  );

  executeStage uExecute (
    .clk           (clk),
    .rstN          (rstN),
    .haz           (haz.execute),
    .opE           (opE),
    .operandAE     (operandAE),
    .operandBE     (operandBE),
    .immE          (immE),
    .pcE           (pcE),
    .srcRegAE      (srcRegAE),
    .srcRegBE      (srcRegBE),
    .destRegE      (destRegE),
    .aluResultM    (aluResultM),
    .resultW       (resultW),
    .branchTakenE  (branchTakenE),
    .branchTargetE (branchTargetE),
    .opM           (opM),
    .aluOutM       (aluResultM),
    .storeDataM    (storeDataM),
    .destRegM      (destRegM)
  );

  memoryStage uMemory (
    .clk         (clk),
    .rstN        (rstN),
    .haz         (haz.memory),
    .opM         (opM),
    .aluOutM     (aluResultM),
    .storeDataM  (storeDataM),
    .destRegM    (destRegM),
    .dmemReq     (dmemReq),
    .dmemWe      (dmemWe),
    .dmemAddr    (dmemAddr),
    .dmemWdata   (dmemWdata),
    .dmemRdata   (dmemRdata),
    .dmemReady   (dmemReady),
    .resultW     (resultW),
    .retireValid (retireValid),
    .retireReg   (retireReg),
    .retireData  (retireData)
  );

endmodule

`default_nettype wire

// ==== bench/pipeCoreTb.sv ====
`default_nettype none

module pipeCoreTb;

  localparam int memDepth = 1 << cpuPkg::addrW;
  localparam int resetCycles = 10;
  localparam int quietCycles = 50;

  logic                        clk = 1'b0;
  logic                        rstN = 1'b0;
  logic [cpuPkg::addrW-1:0]    imemAddr;
  logic [cpuPkg::dataW-1:0]    imemData = '0;
  logic                        imemReady = 1'b0;
  logic                        dmemReq;
  logic                        dmemWe;
  logic [cpuPkg::addrW-1:0]    dmemAddr;
  logic [cpuPkg::dataW-1:0]    dmemWdata;
  logic [cpuPkg::dataW-1:0]    dmemRdata = '0;
  logic                        dmemReady = 1'b0;
  logic                        retireValid;
  logic [cpuPkg::regAddrW-1:0] retireReg;
  logic [cpuPkg::dataW-1:0]    retireData;

  // Instruction and data memory models
  logic [cpuPkg::dataW-1:0]    imemArr [0:memDepth-1];
  logic [cpuPkg::dataW-1:0]    dmemArr [0:memDepth-1];

  // Expected traces, consumed in order
  logic [cpuPkg::regAddrW-1:0] expRetireReg [$];
  logic [cpuPkg::dataW-1:0]    expRetireData [$];
  logic [cpuPkg::addrW-1:0]    expStoreAddr [$];
  logic [cpuPkg::dataW-1:0]    expStoreData [$];

  int          retireIdx = 0;
  int          storeIdx = 0;
  int          cycle = 0;
  int          cycleLimit = 0;
  int          quietCount = 0;
  int          retireErrors = 0;
  int          storeErrors = 0;
  int          otherErrors = 0;
  logic [31:0] rngState = 32'hf2ecf6e3;
  logic        nextImemReady;
  logic        nextDmemReady;
  bit          dataOk;
  bit          done = 1'b0;

  always #10 clk = ~clk;

  pipeCore dut (
    .clk         (clk),
    .rstN        (rstN),
    .imemAddr    (imemAddr),
    .imemData    (imemData),
    .imemReady   (imemReady),
    .dmemReq     (dmemReq),
    .dmemWe      (dmemWe),
    .dmemAddr    (dmemAddr),
    .dmemWdata   (dmemWdata),
    .dmemRdata   (dmemRdata),
    .dmemReady   (dmemReady),
    .retireValid (retireValid),
    .retireReg   (retireReg),
    .retireData  (retireData)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Empty program space is nops, unwritten data shows its own address
  task automatic fillMemories();
    logic [cpuPkg::addrW-1:0] addr;
    for (int i = 0; i < memDepth; i++)
    begin
      addr = i[cpuPkg::addrW-1:0];
      imemArr[addr] = cpuPkg::nopInstr;
      dmemArr[addr] = {~addr, addr};
    end
  endtask

  task automatic loadTestdata(output bit ok);
    int          fd;
    int          code;
    string       line;
    string       tag;
    logic [31:0] colA;
    logic [31:0] colB;
    ok = 1'b0;
    fd = $fopen("bench/pipeTestdata.txt", "r");
    if (fd != 0)
    begin
      ok = 1'b1;
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        // Comment lines never yield three fields with a known tag
        if (code > 0 && $sscanf(line, "%s %h %h", tag, colA, colB) == 3)
        begin
          if (tag == "P")
            imemArr[colA[cpuPkg::addrW-1:0]] = colB;
          else if (tag == "D")
            dmemArr[colA[cpuPkg::addrW-1:0]] = colB;
          else if (tag == "R")
          begin
            expRetireReg.push_back(colA[cpuPkg::regAddrW-1:0]);
            expRetireData.push_back(colB);
          end
          else if (tag == "S")
          begin
            expStoreAddr.push_back(colA[cpuPkg::addrW-1:0]);
            expStoreData.push_back(colB);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Reset leaves the PC at zero with nothing retiring and no memory request
  task automatic compareResetState();
    if (imemAddr !== cpuPkg::addrW'(0))
    begin
      $display("error: imemAddr expected %h got %h", cpuPkg::addrW'(0), imemAddr);
      otherErrors++;
    end
    if (retireValid !== 1'b0)
    begin
      $display("error: retireValid expected %h got %h", 1'b0, retireValid);
      otherErrors++;
    end
    if (dmemReq !== 1'b0)
    begin
      $display("error: dmemReq expected %h got %h", 1'b0, dmemReq);
      otherErrors++;
    end
  endtask

  task automatic checkRetire();
    if (retireIdx >= expRetireReg.size())
    begin
      $display("unexpected retire of register %0d with data %h", retireReg, retireData);
      retireErrors++;
    end
    else
    begin
      if (retireReg != expRetireReg[retireIdx])
      begin
        $display("error: retireReg expected %h got %h", expRetireReg[retireIdx], retireReg);
        retireErrors++;
      end
      if (retireData != expRetireData[retireIdx])
      begin
        $display("error: retireData expected %h got %h", expRetireData[retireIdx], retireData);
        retireErrors++;
      end
      retireIdx++;
    end
  endtask

  task automatic checkStore();
    if (storeIdx >= expStoreAddr.size())
    begin
      $display("unexpected store of %h to address %h", dmemWdata, dmemAddr);
      storeErrors++;
    end
    else
    begin
      if (dmemAddr != expStoreAddr[storeIdx])
      begin
        $display("error: dmemAddr expected %h got %h", expStoreAddr[storeIdx], dmemAddr);
        storeErrors++;
      end
      if (dmemWdata != expStoreData[storeIdx])
      begin
        $display("error: dmemWdata expected %h got %h", expStoreData[storeIdx], dmemWdata);
        storeErrors++;
      end
      storeIdx++;
    end
  endtask

  task automatic finishRun();
    $display("errors: retire %0d, store %0d, other %0d", retireErrors, storeErrors, otherErrors);
    if (retireErrors + storeErrors + otherErrors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  initial
  begin
    fillMemories();
    loadTestdata(dataOk);
    if (!dataOk)
    begin
      $display("could not open the test data file bench/pipeTestdata.txt");
      otherErrors++;
    end
    else
    begin
      cycleLimit = 40 * (expRetireReg.size() + expStoreAddr.size()) + 200;
      while (!done)
      begin
        @(negedge clk);
        cycle++;
        rngState = xorshift(rngState);
        // Each memory is not ready one cycle in four
        nextImemReady = (rngState[1:0] != 2'b00);
        nextDmemReady = (rngState[3:2] != 2'b00);
        if (rstN)
        begin
          if (retireValid)
            checkRetire();
          if (dmemReq && dmemWe && nextDmemReady)
            checkStore();
        end
        else if (cycle == resetCycles)
          compareResetState();
        // Store completes at the coming edge, where the DUT sees ready
        if (dmemReq && dmemWe && nextDmemReady)
          dmemArr[dmemAddr] = dmemWdata;
        rstN <= (cycle >= resetCycles);
        imemReady <= nextImemReady;
        imemData <= imemArr[imemAddr];
        dmemReady <= nextDmemReady;
        dmemRdata <= dmemArr[dmemAddr];
        if (retireIdx == expRetireReg.size() && storeIdx == expStoreAddr.size())
          quietCount++;
        if (quietCount >= quietCycles)
          done = 1'b1;
        else if (cycle >= cycleLimit)
        begin
          $display("run timed out after %0d cycles with %0d of %0d retires and %0d of %0d stores",
                   cycle, retireIdx, expRetireReg.size(), storeIdx, expStoreAddr.size());
          otherErrors++;
          done = 1'b1;
        end
      end
    end
    finishRun();
  end

endmodule

`default_nettype wire

// ==== bench/pipeTestdata.txt ====
# Tag P program word and tag D initial data word, columns: tag, word address, word
# Tag R expected retire (register, value), tag S expected store (address, value)
P 0000 51000005
P 0001 5200000C
P 0002 53000030
P 0003 14120000
P 0004 25410000
P 0005 46540000
P 0006 37630000
P 0007 68300002
P 0008 19810000
P 0009 70390004
P 000A 6A300004
P 000B 80120005
P 000C 80440003
P 000D 5B000BAD
P 000E 70010040
P 000F 2CA20000
P 0010 700C0041
P 0011 5D000077
P 0012 80000000
D 0032 00000100
D 0034 0000DEAD
R 1 00000005
R 2 0000000C
R 3 00000030
R 4 00000011
R 5 0000000C
R 6 0000001D
R 7 00000010
R 8 00000100
R 9 00000105
R A 00000105
R C 000000F9
R D 00000077
S 0034 00000105
S 0041 000000F9

// ==== vlog.f ====
source/cpuPkg.sv
source/hazardIf.sv
source/hazardUnit.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/pipeCore.sv
bench/pipeCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module pipeCoreTb -Mdir obj_dir -o simPipeCore
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simPipeCore)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
